// File: design/jy_pkg.sv
// Widths assume a 16-bit CPU bus and 22-bit PRG addresses in 8K pages; four PRG bank registers
package jy_pkg;

	// Bus widths
	localparam int cpu_addr_w = 16;
	localparam int prg_addr_w = 22;
	localparam int data_w     = 8;
	localparam int product_w  = 16;

	// PRG bank registers at $8000-$8003
	localparam int bank_count = 4;
	localparam int bank_sel_w = $clog2(bank_count);

	// Multiplier latency in clk cycles, one per operand bit
	localparam int mul_steps = 8;
	localparam int mul_idx_w = $clog2(mul_steps);

	// Registers that can be read back over the CPU bus
	localparam logic [cpu_addr_w-1:0] addr_mul_lo   = 16'h5800;
	localparam logic [cpu_addr_w-1:0] addr_mul_hi   = 16'h5801;
	localparam logic [cpu_addr_w-1:0] addr_acc      = 16'h5802;
	localparam logic [cpu_addr_w-1:0] addr_acc_test = 16'h5803;

	// Decoded CPU write operations
	typedef enum logic [3:0] {
		op_none,
		op_mul_a,     // $5800
		op_mul_b,     // $5801 starts a multiply
		op_acc_add,   // $5802
		op_acc_clr,   // $5803 also loads the test register
		op_prg_bank,  // $8000-$8003
		op_irq_ctrl,  // $C000
		op_irq_mode,  // $C001
		op_irq_dis,   // $C002
		op_irq_en,    // $C003
		op_irq_pre,   // $C004
		op_irq_cnt,   // $C005
		op_irq_xor,   // $C006
		op_bank_mode, // $D000
		op_outer      // $D003
	} reg_op_e;

	// Multiplier sequencer
	typedef enum logic {
		mul_idle,
		mul_busy
	} mul_state_e;

endpackage

// File: design/jy_ifs.sv
// Bank configuration is held as levels and start is a single-clk pulse with no handshake
`timescale 1ns/1ps

interface jy_cfg_if;
	import jy_pkg::*;

	logic [data_w-1:0] prg_bank [bank_count]; // $8000-$8003
	logic [data_w-1:0] bank_mode;             // $D000
	logic [data_w-1:0] outer_bank;            // $D003

	modport regs_mp (output prg_bank, output bank_mode, output outer_bank);
	modport map_mp (input prg_bank, input bank_mode, input outer_bank);
endinterface

interface jy_mul_if;
	import jy_pkg::*;

	logic                 start;   // One clk wide
	logic [data_w-1:0]    a;
	logic [data_w-1:0]    b;
	logic [product_w-1:0] product;
	logic                 busy;

	modport ctrl_mp (output start, output a, output b, input product, input busy);
	modport dp_mp (input start, input a, input b, output product, output busy);
endinterface

// File: design/jy_regs.sv
// Register file with partial address decode; CPU writes must be at least two clk cycles apart
`timescale 1ns/1ps

module jy_regs (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ce,
	input  logic                          prg_write,
	input  logic [jy_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic [jy_pkg::data_w-1:0]     prg_din,
	jy_cfg_if.regs_mp                     cfg,
	jy_mul_if.ctrl_mp                     mul,
	output logic                          irq_wr,
	output jy_pkg::reg_op_e               irq_op,
	output logic [jy_pkg::data_w-1:0]     irq_data,
	output logic [jy_pkg::data_w-1:0]     prg_dout,
	output logic                          prg_bus_write
);
	import jy_pkg::*;

	reg_op_e           wr_op;
	logic              wr;
	logic [data_w-1:0] prg_bank [bank_count];
	logic [data_w-1:0] bank_mode;
	logic [data_w-1:0] outer_bank;
	logic [data_w-1:0] mul_a;
	logic [data_w-1:0] mul_b;
	logic              start;
	logic [data_w-1:0] acc;
	logic [data_w-1:0] acc_test;

	assign wr = ce && prg_write;

	// Only A15-A11 and A2-A0 take part in the decode
	always_comb begin
		casez ({prg_ain[15:11], prg_ain[2:0]})
			8'b01011_?00: wr_op = op_mul_a;
			8'b01011_?01: wr_op = op_mul_b;
			8'b01011_?10: wr_op = op_acc_add;
			8'b01011_?11: wr_op = op_acc_clr;
			8'b10000_???: wr_op = op_prg_bank;
			8'b11000_000: wr_op = op_irq_ctrl;
			8'b11000_001: wr_op = op_irq_mode;
			8'b11000_010: wr_op = op_irq_dis;
			8'b11000_011: wr_op = op_irq_en;
			8'b11000_100: wr_op = op_irq_pre;
			8'b11000_101: wr_op = op_irq_cnt;
			8'b11000_110: wr_op = op_irq_xor;
			8'b11010_?00: wr_op = op_bank_mode;
			8'b11010_?11: wr_op = op_outer;
			default:      wr_op = op_none;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < bank_count; i++)
				prg_bank[i] <= '0;
			bank_mode  <= '0;
			outer_bank <= '0;
			mul_a      <= '0;
			mul_b      <= '0;
			start      <= 1'b0;
			acc        <= '0;
			acc_test   <= '0;
		end else begin
			start <= 1'b0; // Pulse only
			if (wr) begin
				case (wr_op)
					op_mul_a:     mul_a <= prg_din;
					op_mul_b: begin
						mul_b <= prg_din;
						start <= 1'b1;
					end
					op_acc_add:   acc <= acc + prg_din;
					op_acc_clr: begin
						acc      <= '0;
						acc_test <= prg_din;
					end
					op_prg_bank:  prg_bank[prg_ain[bank_sel_w-1:0]] <= prg_din;
					op_bank_mode: bank_mode <= prg_din;
					op_outer:     outer_bank <= prg_din;
					default:      ;
				endcase
			end
		end
	end

	// IRQ writes are handed over in the same cycle
	assign irq_wr   = wr && (wr_op inside {[op_irq_ctrl:op_irq_xor]});
	assign irq_op   = wr_op;
	assign irq_data = prg_din;

	assign cfg.prg_bank   = prg_bank;
	assign cfg.bank_mode  = bank_mode;
	assign cfg.outer_bank = outer_bank;
	assign mul.start      = start;
	assign mul.a          = mul_a;
	assign mul.b          = mul_b;

	always_comb begin
		prg_bus_write = 1'b1;
		case (prg_ain)
			addr_mul_lo:   prg_dout = mul.product[7:0];
			addr_mul_hi:   prg_dout = mul.product[15:8];
			addr_acc:      prg_dout = acc;
			addr_acc_test: prg_dout = acc_test;
			default: begin
				prg_dout      = 8'hFF; // Open bus
				prg_bus_write = 1'b0;
			end
		endcase
	end

	// Back-to-back $5801 writes would break the restart timing of the multiplier
	a_start_pulse: assert property (@(posedge clk) disable iff (rst) mul.start |=> !mul.start);

endmodule

// File: design/jy_prg_map.sv
// Combinational CPU to PRG ROM translation; no PRG RAM, so $6000-$7FFF is ROM or denied
`timescale 1ns/1ps

module jy_prg_map (
	input  logic [jy_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic                          prg_write,
	jy_cfg_if.map_mp                      cfg,
	output logic [jy_pkg::prg_addr_w-1:0] prg_aout,
	output logic                          prg_allow
);
	import jy_pkg::*;

	logic                  prg_6xxx;
	logic                  prg_denied;
	logic [bank_sel_w-1:0] prg_reg;
	logic [data_w-1:0]     bank_val;
	logic [6:0]            rev_bank;
	logic [6:0]            bank_order;
	logic [5:0]            prg_sel;

	assign prg_6xxx   = (prg_ain[15:13] == 3'b011);
	assign prg_denied = prg_6xxx && !cfg.bank_mode[7]; // ROM window not enabled

	// Which bank register serves this address
	always_comb begin
		casez ({prg_6xxx, cfg.bank_mode[1:0]})
			3'b000:  prg_reg = 2'b11;                   // 32K
			3'b001:  prg_reg = {prg_ain[14], 1'b1};     // 16K
			3'b01?:  prg_reg = prg_ain[14:13];          // 8K
			default: prg_reg = 2'b11;                   // $6000-$7FFF
		endcase
	end

	// Last slot is fixed to FF unless bank_mode[2]
	assign bank_val = (!cfg.bank_mode[2] && prg_reg == 2'b11) ? 8'hFF : cfg.prg_bank[prg_reg];

	always_comb begin
		for (int i = 0; i < 7; i++)
			rev_bank[i] = bank_val[6 - i];
	end

	assign bank_order = (cfg.bank_mode[1:0] == 2'b11) ? rev_bank : bank_val[6:0];

	// 8K page number inside the outer bank
	always_comb begin
		casez ({prg_6xxx, cfg.bank_mode[1:0]})
			3'b000:  prg_sel = {bank_order[3:0], prg_ain[14:13]};
			3'b001:  prg_sel = {bank_order[4:0], prg_ain[13]};
			3'b?1?:  prg_sel = bank_order[5:0];
			3'b100:  prg_sel = {bank_order[3:0], 2'b11};
			default: prg_sel = {bank_order[4:0], 1'b1};
		endcase
	end

	assign prg_aout  = {1'b0, cfg.outer_bank[2:1], prg_sel, prg_ain[12:0]};
	assign prg_allow = (prg_ain >= 16'h6000) && !prg_denied && !prg_write;

endmodule

// File: design/jy_multiplier.sv
// Shift-and-add 8x8 multiplier; a start while busy restarts from the new operands
`timescale 1ns/1ps

module jy_multiplier (
	input  logic      clk,
	input  logic      rst,
	jy_mul_if.dp_mp   mul
);
	import jy_pkg::*;

	mul_state_e           state;
	logic [mul_idx_w-1:0] idx;
	logic [product_w-1:0] shift_a;
	logic [data_w-1:0]    b_reg;
	logic [product_w-1:0] product;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= mul_idle;
			idx     <= '0;
			product <= '0;
		end else if (mul.start) begin
			state   <= mul_busy;
			idx     <= '0;
			product <= '0;
		end else if (state == mul_busy) begin
			product <= product + (b_reg[idx] ? shift_a : '0);
			idx     <= idx + 1'b1;
			if (idx == mul_idx_w'(mul_steps - 1))
				state <= mul_idle; // Last partial product
		end
	end

	// Operand datapath
	always_ff @(posedge clk) begin
		if (mul.start) begin
			shift_a <= {{(product_w - data_w){1'b0}}, mul.a};
			b_reg   <= mul.b;
		end else if (state == mul_busy) begin
			shift_a <= shift_a << 1;
		end
	end

	assign mul.product = product;
	assign mul.busy    = (state == mul_busy);

	a_busy_len: assert property (@(posedge clk) disable iff (rst)
		mul.start ##1 (!mul.start) [*mul_steps] |-> mul.busy ##1 !mul.busy);

endmodule

// File: design/jy_irq_counter.sv
// IRQ prescaler and counter; only the CPU clock and CPU write sources tick, PPU sources never do
`timescale 1ns/1ps

module jy_irq_counter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ce,
	input  logic                          prg_write,
	input  logic                          irq_wr,
	input  jy_pkg::reg_op_e               irq_op,
	input  logic [jy_pkg::data_w-1:0]     irq_data,
	output logic                          irq
);
	import jy_pkg::*;

	logic [data_w-1:0] mode;
	logic [data_w-1:0] xor_key;
	logic [data_w-1:0] prescaler;
	logic [data_w-1:0] count;
	logic              enable;
	logic              en_l;
	logic              dis_l;
	logic              pending;
	logic              tick;
	logic              step;
	logic              pre_term;
	logic              cnt_term;

	assign tick = (mode[1:0] == 2'b00 && ce) || (mode[1:0] == 2'b11 && ce && prg_write);
	assign step = tick && enable && (mode[7] != mode[6]);

	// Terminal values depend on direction and the 3-bit prescaler mode
	always_comb begin
		if (mode[6])
			pre_term = mode[2] ? (prescaler[2:0] == 3'h7) : (prescaler == 8'hFF);
		else
			pre_term = mode[2] ? (prescaler[2:0] == 3'h0) : (prescaler == 8'h00);
		cnt_term = mode[6] ? (count == 8'hFF) : (count == 8'h00);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mode      <= '0;
			xor_key   <= '0;
			prescaler <= '0;
			count     <= '0;
			enable    <= 1'b0;
			en_l      <= 1'b0;
			dis_l     <= 1'b0;
			pending   <= 1'b0;
		end else begin
			if (irq_wr) begin
				case (irq_op)
					op_irq_ctrl: begin
						en_l  <= irq_data[0];
						dis_l <= !irq_data[0];
					end
					op_irq_mode: mode <= irq_data;
					op_irq_dis:  dis_l <= 1'b1;
					op_irq_en:   en_l <= 1'b1;
					op_irq_pre:  prescaler <= irq_data ^ xor_key;
					op_irq_cnt:  count <= irq_data ^ xor_key;
					op_irq_xor:  xor_key <= irq_data;
					default:     ;
				endcase
			end
			if (step) begin
				prescaler <= mode[6] ? prescaler + 8'd1 : prescaler - 8'd1;
				if (pre_term) begin
					count <= mode[6] ? count + 8'd1 : count - 8'd1;
					if (cnt_term)
						pending <= 1'b1;
				end
			end
			// Latched enable and disable take effect one cycle after the write
			if (dis_l) begin
				pending   <= 1'b0;
				prescaler <= '0;
				enable    <= 1'b0;
				dis_l     <= 1'b0;
			end else if (en_l) begin
				en_l   <= 1'b0;
				enable <= 1'b1;
			end
		end
	end

	assign irq = pending && enable;

	// Pending can never outlive the enable flag
	a_pend_en: assert property (@(posedge clk) disable iff (rst) pending |-> enable);

endmodule

// File: design/jy_mapper.sv
// Top level of the CPU side; ce must be a single-clk strobe and writes at least two clks apart
`timescale 1ns/1ps

module jy_mapper (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ce,
	input  logic                          prg_write,
	input  logic [jy_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic [jy_pkg::data_w-1:0]     prg_din,
	output logic [jy_pkg::data_w-1:0]     prg_dout,
	output logic                          prg_bus_write,
	output logic [jy_pkg::prg_addr_w-1:0] prg_aout,
	output logic                          prg_allow,
	output logic                          irq
);
	import jy_pkg::*;

	jy_cfg_if cfg_bus ();
	jy_mul_if mul_bus ();

	logic              irq_wr;
	reg_op_e           irq_op;
	logic [data_w-1:0] irq_data;

	jy_regs regs_i (
		.clk           (clk),
		.rst           (rst),
		.ce            (ce),
		.prg_write     (prg_write),
		.prg_ain       (prg_ain),
		.prg_din       (prg_din),
		.cfg           (cfg_bus.regs_mp),
		.mul           (mul_bus.ctrl_mp),
		.irq_wr        (irq_wr),
		.irq_op        (irq_op),
		.irq_data      (irq_data),
		.prg_dout      (prg_dout),
		.prg_bus_write (prg_bus_write)
	);

	jy_prg_map prg_map_i (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.cfg       (cfg_bus.map_mp),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	jy_multiplier multiplier_i (
		.clk (clk),
		.rst (rst),
		.mul (mul_bus.dp_mp)
	);

	jy_irq_counter irq_counter_i (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.prg_write (prg_write),
		.irq_wr    (irq_wr),
		.irq_op    (irq_op),
		.irq_data  (irq_data),
		.irq       (irq)
	);

endmodule

// File: bench/jy_checker.sv
// Compares at each rising edge outside reset; prg_bus_write every cycle, other outputs when masked
`timescale 1ns/1ps

module jy_checker (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [jy_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic [jy_pkg::data_w-1:0]     prg_dout,
	input  logic                          prg_bus_write,
	input  logic [jy_pkg::prg_addr_w-1:0] prg_aout,
	input  logic                          prg_allow,
	input  logic                          irq,
	input  logic [3:0]                    chk,        // irq, allow, aout, read data
	input  logic [jy_pkg::data_w-1:0]     exp_dout,
	input  logic                          exp_bus_write,
	input  logic [jy_pkg::prg_addr_w-1:0] exp_aout,
	input  logic                          exp_allow,
	input  logic                          exp_irq,
	output int                            error_count,
	output int                            check_count
);
	import jy_pkg::*;

	int errors = 0;
	int checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] %0d ns: %s", $time, msg);
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			// Only the four arithmetic registers drive the data bus
			if (prg_bus_write !== (prg_ain inside {[addr_mul_lo:addr_acc_test]}))
				report_error($sformatf("prg_bus_write %b at address %h", prg_bus_write, prg_ain));
			if (chk[0]) begin
				checks++;
				if (prg_dout !== exp_dout || prg_bus_write !== exp_bus_write)
					report_error($sformatf("read %h gave %h/%b, expected %h/%b", prg_ain,
						prg_dout, prg_bus_write, exp_dout, exp_bus_write));
			end
			if (chk[1]) begin
				checks++;
				if (prg_aout !== exp_aout)
					report_error($sformatf("address %h mapped to %h, expected %h", prg_ain,
						prg_aout, exp_aout));
			end
			if (chk[2]) begin
				checks++;
				if (prg_allow !== exp_allow)
					report_error($sformatf("allow %b at %h, expected %b", prg_allow, prg_ain,
						exp_allow));
			end
			if (chk[3]) begin
				checks++;
				if (irq !== exp_irq)
					report_error($sformatf("irq %b, expected %b", irq, exp_irq));
			end
		end
	end

endmodule

// File: bench/tb_jy_mapper.sv
// Self-checking testbench; CPU writes are spaced two clocks apart and ce strobes last one clock
`timescale 1ns/1ps

module tb_jy_mapper;
	import jy_pkg::*;

	localparam int cycle_limit = 4000; // Roughly three times the longest run

	logic clk, rst, ce, prg_write, prg_bus_write, prg_allow, irq;
	logic [cpu_addr_w-1:0] prg_ain;
	logic [data_w-1:0]     prg_din, prg_dout;
	logic [prg_addr_w-1:0] prg_aout, exp_aout;
	logic [3:0]            chk;
	logic [data_w-1:0]     exp_dout, mode, key, pre, cnt, acc_sum, test_val;
	logic                  exp_bus_write, exp_allow, exp_irq;
	logic [product_w-1:0]  prod;
	logic [31:0]           rnd;
	logic [data_w-1:0]     m_bank [bank_count]; // Model copy of the register file
	logic [data_w-1:0]     m_mode, m_outer;
	int                    error_count, check_count, ticks, cycle_count;
	integer                seed = 32'hd8da;

	jy_mapper jy_mapper_i (.*);

	jy_checker checker_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [prg_addr_w:0] ref_prg_addr(input logic [15:0] addr, input logic wr);
		logic       low_win;
		logic [1:0] slot;
		logic [7:0] bank;
		logic [7:0] page;
		logic       allow;
		low_win = (addr[15:13] == 3'b011);
		case (m_mode[1:0])
			2'd0:    slot = 2'd3;
			2'd1:    slot = low_win ? 2'd3 : {addr[14], 1'b1};
			default: slot = low_win ? 2'd3 : addr[14:13];
		endcase
		bank = (slot == 2'd3 && !m_mode[2]) ? 8'hFF : m_bank[slot];
		if (m_mode[1:0] == 2'd3)
			bank = {1'b0, bank[0], bank[1], bank[2], bank[3], bank[4], bank[5], bank[6]};
		case (m_mode[1:0])
			2'd0:    page = {bank[5:0], low_win ? 2'b11 : addr[14:13]};
			2'd1:    page = {bank[6:0], low_win ? 1'b1 : addr[13]};
			default: page = bank;
		endcase
		allow = (addr >= 16'h6000) && !wr && !(low_win && !m_mode[7]);
		return {allow, 1'b0, m_outer[2:1], page[5:0], addr[12:0]};
	endfunction

	function automatic logic [product_w-1:0] ref_product(input logic [7:0] a, input logic [7:0] b);
		return product_w'(a) * product_w'(b);
	endfunction

	// Down count steps once the prescaler runs out and then once per period
	function automatic int ref_irq_ticks(input logic [7:0] p, input logic [7:0] c, input logic p3);
		return p3 ? (int'(p[2:0]) + 1 + int'(c) * 8) : (int'(p) + 1 + int'(c) * 256);
	endfunction

	task automatic bus_write(input logic [cpu_addr_w-1:0] addr, input logic [data_w-1:0] data);
		prg_ain   = addr;
		prg_din   = data;
		ce        = 1'b1;
		prg_write = 1'b1;
		@(negedge clk);
		ce        = 1'b0;
		prg_write = 1'b0;
		@(negedge clk); // Gap between writes
	endtask

	task automatic read_check(input logic [cpu_addr_w-1:0] addr, input logic [data_w-1:0] data,
		input logic bw);
		prg_ain       = addr;
		exp_dout      = data;
		exp_bus_write = bw;
		chk           = 4'b0001;
		@(negedge clk);
		chk = '0;
	endtask

	task automatic map_check(input logic [cpu_addr_w-1:0] addr, input logic wr);
		logic [prg_addr_w:0] r;
		r         = ref_prg_addr(addr, wr);
		prg_ain   = addr;
		prg_write = wr;
		exp_allow = r[prg_addr_w];
		exp_aout  = r[prg_addr_w-1:0];
		chk       = (addr[15:13] == 3'b011 && !m_mode[7]) ? 4'b0100 : 4'b0110;
		@(negedge clk);
		chk       = '0;
		prg_write = 1'b0;
	endtask

	task automatic irq_check(input logic level);
		exp_irq = level;
		chk     = 4'b1000;
		@(negedge clk);
		chk = '0;
	endtask

	task automatic ce_pulses(input int n);
		repeat (n) begin
			ce = 1'b1;
			@(negedge clk);
			ce = 1'b0;
			@(negedge clk);
		end
	endtask

	task automatic load_config(input logic [data_w-1:0] bank_mode);
		for (int i = 0; i < bank_count; i++) begin
			rnd       = $random(seed);
			m_bank[i] = rnd[7:0];
			bus_write(cpu_addr_w'(32'h8000 + i), rnd[7:0]);
		end
		rnd     = $random(seed);
		m_mode  = bank_mode;
		m_outer = rnd[7:0];
		bus_write(16'hD000, bank_mode);
		bus_write(16'hD003, rnd[7:0]);
	endtask

	initial begin
		rst           = 1'b1;
		ce            = 1'b0;
		prg_write     = 1'b0;
		prg_ain       = '0;
		prg_din       = '0;
		chk           = '0;
		exp_dout      = '0;
		exp_bus_write = 1'b0;
		exp_aout      = '0;
		exp_allow     = 1'b0;
		exp_irq       = 1'b0;
		m_mode  = '0;
		m_outer = '0;
		for (int i = 0; i < bank_count; i++)
			m_bank[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		irq_check(1'b0);
		read_check(addr_mul_lo, 8'h00, 1'b1);
		read_check(16'h4000, 8'hFF, 1'b0);
		map_check(16'hE000, 1'b0);
		for (int k = 0; k < 16; k++) begin // Mode, bit 2 and bit 7 of bank_mode
			rnd  = $random(seed);
			mode = {k[3], rnd[6:3], k[2], k[1:0]};
			load_config(mode);
			for (int r = 3; r < 8; r++) begin
				rnd = $random(seed);
				map_check({r[2:0], rnd[12:0]}, 1'b0);
			end
			map_check({3'b111, rnd[25:13]}, 1'b1);
		end
		for (int n = 0; n < 9; n++) begin
			rnd = $random(seed);
			if (n == 0)
				rnd[15:0] = 16'hFFFF;
			if (n == 8) begin // Restart while busy
				bus_write(addr_mul_lo, rnd[23:16]);
				bus_write(addr_mul_hi, rnd[31:24]);
			end
			bus_write(addr_mul_lo, rnd[7:0]);
			bus_write(addr_mul_hi, rnd[15:8]);
			repeat (mul_steps) @(negedge clk);
			prod = ref_product(rnd[7:0], rnd[15:8]);
			read_check(addr_mul_lo, prod[7:0], 1'b1);
			read_check(addr_mul_hi, prod[15:8], 1'b1);
		end
		rnd = $random(seed);
		bus_write(addr_acc, rnd[7:0]);
		bus_write(addr_acc, rnd[15:8]);
		test_val = rnd[23:16];
		acc_sum  = '0;
		bus_write(addr_acc_test, test_val);
		repeat (6) begin
			rnd     = $random(seed);
			acc_sum = acc_sum + rnd[7:0];
			bus_write(addr_acc, rnd[7:0]);
		end
		read_check(addr_acc, acc_sum, 1'b1);
		read_check(addr_acc_test, test_val, 1'b1);
		// First run counts down with the full 8-bit prescaler
		rnd = $random(seed);
		key = rnd[7:0];
		pre = {2'b00, rnd[13:8]};
		cnt = 8'd1;
		bus_write(16'hC001, 8'h80);
		bus_write(16'hC006, key);
		bus_write(16'hC004, pre ^ key);
		bus_write(16'hC005, cnt ^ key);
		bus_write(16'hC003, 8'h00);
		ticks = ref_irq_ticks(pre, cnt, 1'b0);
		ce_pulses(ticks - 1);
		irq_check(1'b0);
		ce_pulses(1);
		irq_check(1'b1);
		bus_write(16'hC002, 8'h00);
		irq_check(1'b0);
		// Second run relies on the cleared prescaler
		rnd = $random(seed);
		key = rnd[7:0];
		cnt = {4'h0, rnd[11:8]};
		bus_write(16'hC001, 8'h84);
		bus_write(16'hC006, key);
		bus_write(16'hC005, cnt ^ key);
		bus_write(16'hC003, 8'h00);
		ticks = ref_irq_ticks(8'h00, cnt, 1'b1);
		ce_pulses(ticks - 1);
		irq_check(1'b0);
		ce_pulses(1);
		irq_check(1'b1);
		@(negedge clk);
		$display("Checks: %0d  Errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tb.f
design/jy_pkg.sv
design/jy_ifs.sv
design/jy_regs.sv
design/jy_prg_map.sv
design/jy_multiplier.sv
design/jy_irq_counter.sv
design/jy_mapper.sv
bench/jy_checker.sv
bench/tb_jy_mapper.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_jy_mapper
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
